// File: Makefile
TOP = tb_map_004_s3

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP)

run: build
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	verilator --lint-only --timing --assert -Wall -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// File: a12_edge_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module a12_edge_fsm (
	input  logic clk,
	input  logic rst_n,
	input  logic a12,
	output logic a12_fall
);
	import map_pkg::*;

	a12_state_e state;
	a12_state_e state_nxt;
	logic       a12_smp;

	// input sample, first of the three clocks to irq.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			a12_smp <= 1'b0;
		end else begin
			a12_smp <= a12;
		end
	end

	// ------------------------------------------------------------
	// edge qualifier.
	// ------------------------------------------------------------

	// idle waits for a first high, so a line low at reset is no edge.
	always_comb begin
		state_nxt = state;
		case (state)
			a12_idle: begin
				if (a12_smp) state_nxt = a12_high;
			end
			a12_high: begin
				if (!a12_smp) state_nxt = a12_low;
			end
			a12_low: begin
				if (a12_smp) state_nxt = a12_high;
			end
			default: state_nxt = a12_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= a12_idle;
			a12_fall <= 1'b0;
		end else begin
			state    <= state_nxt;
			// one pulse per high to low move.
			a12_fall <= (state == a12_high) && (state_nxt == a12_low);
		end
	end

endmodule

`default_nettype wire

// File: addr_map.sv
`timescale 1ns/1ps
`default_nettype none

`include "map_consts.svh"

module addr_map (
	input  map_pkg::cpu_bus_t  cpu,
	input  map_pkg::ppu_bus_t  ppu,
	input  map_pkg::reg_file_t regs,
	output map_pkg::mem_ctrl_t prg,
	output map_pkg::mem_ctrl_t chr,
	output map_pkg::mem_ctrl_t srm,
	output logic               ciram_a10,
	output logic               ciram_ce
);
	import map_pkg::*;

	logic [`MAP_PRG_W-1:13] prg_bank;
	logic [`MAP_PRG_W-1:13] prg_last;
	logic [`MAP_PRG_W-1:13] prg_r6;
	logic [`MAP_CHR_W-1:10] chr_bank;
	logic                   chr_half;
	logic                   ram_win;

	assign prg_last = '1;
	assign prg_r6   = regs.r[`MAP_R_PRG_A][`MAP_PRG_W-14:0];

	// ------------------------------------------------------------
	// PRG, 8 KiB slots.
	// ------------------------------------------------------------
	always_comb begin
		case (cpu.addr[14:13])
			2'd0:    prg_bank = regs.prg_mode ? prg_last - 1'b1 : prg_r6;
			2'd1:    prg_bank = regs.r[`MAP_R_PRG_B][`MAP_PRG_W-14:0];
			2'd2:    prg_bank = regs.prg_mode ? prg_r6 : prg_last - 1'b1;
			default: prg_bank = prg_last;
		endcase
		prg.ce   = cpu.addr[15];
		prg.oe   = cpu.rw;
		prg.we   = 1'b0;
		prg.addr = {prg_bank, cpu.addr[12:0]};
	end

	// ------------------------------------------------------------
	// CHR, two 2 KiB and four 1 KiB banks.
	// ------------------------------------------------------------
	assign chr_half = ppu.addr[12] ^ regs.chr_inv;

	always_comb begin
		if (!chr_half) begin
			// low bit of r0/r1 comes from PPU A10.
			chr_bank = {regs.r[ppu.addr[11]][7:1], ppu.addr[10]};
		end else begin
			chr_bank = regs.r[3'd2 + {1'b0, ppu.addr[11:10]}];
		end
		chr.ce   = !ppu.addr[13];
		chr.oe   = !ppu.oe_n;
		chr.we   = 1'b0;
		chr.addr = {{(`MAP_PRG_W-`MAP_CHR_W){1'b0}}, chr_bank, ppu.addr[9:0]};
	end

	// work RAM, single 8 KiB part.
	assign ram_win = (cpu.addr & `MAP_RAM_MASK) == `MAP_RAM_BASE;

	always_comb begin
		srm.ce   = ram_win && regs.ram_en;
		srm.oe   = cpu.rw;
		srm.we   = ram_win && regs.ram_en && !regs.ram_wp && !cpu.rw && cpu.m2;
		srm.addr = {{(`MAP_PRG_W-13){1'b0}}, cpu.addr[12:0]};
	end

	// nametables. A10 for vertical, A11 for horizontal.
	assign ciram_a10 = regs.mir_v ? ppu.addr[10] : ppu.addr[11];
	assign ciram_ce  = !ppu.addr[13];

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
map_pkg.sv
mmc3_regs.sv
addr_map.sv
a12_edge_fsm.sv
irq_acc.sv
map_004_s3.sv
map_004_s3_chk.sv
tb_map_004_s3.sv

// File: irq_acc.sv
`timescale 1ns/1ps
`default_nettype none

`include "map_consts.svh"

module irq_acc (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             a12_fall,
	input  logic             irq_wr,
	input  map_pkg::reg_op_e irq_op,
	input  logic [7:0]       irq_data,
	output logic             irq
);
	import map_pkg::*;

	logic [7:0] latch;
	logic [7:0] counter;
	logic [7:0] cnt_nxt;
	logic [2:0] presc;
	logic       reload_pend;
	logic       irq_en;
	logic       tick;

	// eighth fall of each group.
	assign tick = a12_fall && (presc == 3'(`MAP_PRESCALE - 1));

	always_comb begin
		if (counter == 8'd0 || reload_pend) begin
			cnt_nxt = latch;
		end else begin
			cnt_nxt = counter - 8'd1;
		end
	end

	// ------------------------------------------------------------
	// prescaler, counter and irq line.
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			latch       <= 8'd0;
			counter     <= 8'd0;
			presc       <= 3'd0;
			reload_pend <= 1'b0;
			irq_en      <= 1'b0;
			irq         <= 1'b0;
		end else begin
			if (a12_fall) presc <= presc + 3'd1;
			if (tick) begin
				counter     <= cnt_nxt;
				reload_pend <= 1'b0;
				if (cnt_nxt == 8'd0 && irq_en) irq <= 1'b1;
			end

			// cpu writes win over a coincident tick.
			if (irq_wr) begin
				case (irq_op)
					op_irq_latch: latch <= irq_data;
					op_irq_reload: begin
						counter     <= 8'd0;
						presc       <= 3'd0;
						reload_pend <= 1'b1;
					end
					op_irq_disable: begin
						irq_en <= 1'b0;
						irq    <= 1'b0;
					end
					op_irq_enable: irq_en <= 1'b1;
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: map_004_s3.sv
`timescale 1ns/1ps
`default_nettype none

// Acclaim MMC3 variant. Same banking as MMC3, divided A12 irq clock.
module map_004_s3 (
	input  logic               clk,
	input  logic               rst_n,
	input  map_pkg::cpu_bus_t  cpu,
	input  map_pkg::ppu_bus_t  ppu,
	input  map_pkg::map_cfg_t  cfg,
	output map_pkg::mem_ctrl_t prg,
	output map_pkg::mem_ctrl_t chr,
	output map_pkg::mem_ctrl_t srm,
	output logic               ciram_a10,
	output logic               ciram_ce,
	output logic               irq
);
	import map_pkg::*;

	reg_file_t  regs;
	logic       irq_wr;
	reg_op_e    irq_op;
	logic [7:0] irq_data;
	logic       a12_fall;

	// ------------------------------------------------------------
	// register decode.
	// ------------------------------------------------------------
	mmc3_regs mmc3_regs_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.cpu      (cpu),
		.cfg      (cfg),
		.regs     (regs),
		.irq_wr   (irq_wr),
		.irq_op   (irq_op),
		.irq_data (irq_data)
	);

	// ------------------------------------------------------------
	// bus mapping.
	// ------------------------------------------------------------
	addr_map addr_map_inst (
		.cpu       (cpu),
		.ppu       (ppu),
		.regs      (regs),
		.prg       (prg),
		.chr       (chr),
		.srm       (srm),
		.ciram_a10 (ciram_a10),
		.ciram_ce  (ciram_ce)
	);

	// ------------------------------------------------------------
	// irq, Acclaim style.
	// ------------------------------------------------------------
	a12_edge_fsm a12_edge_fsm_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.a12      (ppu.addr[12]),
		.a12_fall (a12_fall)
	);

	irq_acc irq_acc_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.a12_fall (a12_fall),
		.irq_wr   (irq_wr),
		.irq_op   (irq_op),
		.irq_data (irq_data),
		.irq      (irq)
	);

endmodule

`default_nettype wire

// File: map_004_s3_chk.sv
`timescale 1ns/1ps
`default_nettype none

module map_004_s3_chk (
	input logic               clk,
	input logic               rst_n,
	input map_pkg::cpu_bus_t  cpu,
	input map_pkg::mem_ctrl_t prg,
	input map_pkg::mem_ctrl_t srm,
	input logic               irq
);
	logic dis_wr;

	// CPU write to 0xE000, the irq disable register.
	assign dis_wr = cpu.m3 && !cpu.rw && (cpu.addr[15:13] == 3'b111) && !cpu.addr[0];

	// quiet outputs while reset is held.
	reset_quiet: assert property (@(posedge clk) !rst_n |=> !irq && !srm.ce)
		else $error("irq or srm.ce high after a reset clock");

	ce_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(prg.ce && srm.ce))
		else $error("prg.ce and srm.ce both high");

	// acknowledge lands on the next clock.
	irq_ack: assert property (@(posedge clk) disable iff (!rst_n) dis_wr |=> !irq)
		else $error("irq still high after a disable write");

endmodule

bind map_004_s3 map_004_s3_chk map_004_s3_chk_inst (
	.clk   (clk),
	.rst_n (rst_n),
	.cpu   (cpu),
	.prg   (prg),
	.srm   (srm),
	.irq   (irq)
);

`default_nettype wire

// File: map_consts.svh
`ifndef MAP_CONSTS_SVH
`define MAP_CONSTS_SVH

// ------------------------------------------------------------
// address widths of the external memories.
// ------------------------------------------------------------
`define MAP_PRG_W 19
`define MAP_CHR_W 18

// work RAM window, 0x6000 to 0x7FFF.
`define MAP_RAM_BASE 16'h6000
`define MAP_RAM_MASK 16'hE000

// bank register indices for the two switchable PRG slots.
`define MAP_R_PRG_A 6
`define MAP_R_PRG_B 7

// reset value of every bank register.
`define MAP_REG_DEFAULT 8'h00

// Acclaim boards count A12 falls in groups of eight.
`define MAP_PRESCALE 8

`endif

// File: map_pkg.sv
`default_nettype none

`include "map_consts.svh"

package map_pkg;

	// ------------------------------------------------------------
	// host buses.
	// ------------------------------------------------------------
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        rw;
		logic        m2;
		logic        m3;
	} cpu_bus_t;

	typedef struct packed {
		logic [13:0] addr;
		logic        oe_n;
	} ppu_bus_t;

	// board strap, hard-wired mirroring.
	typedef struct packed {
		logic mir_h;
	} map_cfg_t;

	// one memory port, shared shape for prg, chr and srm.
	typedef struct packed {
		logic                  ce;
		logic                  oe;
		logic                  we;
		logic [`MAP_PRG_W-1:0] addr;
	} mem_ctrl_t;

	// ------------------------------------------------------------
	// mapper register file.
	// ------------------------------------------------------------
	typedef struct packed {
		logic [2:0]      bank_sel;
		logic            prg_mode;
		logic            chr_inv;
		logic [7:0][7:0] r;
		logic            mir_v;
		logic            ram_en;
		logic            ram_wp;
	} reg_file_t;

	// opcode is {a14, a13, a0} of the write.
	typedef enum logic [2:0] {
		op_bank_sel    = 3'b000,
		op_bank_data   = 3'b001,
		op_mirror      = 3'b010,
		op_ram_prot    = 3'b011,
		op_irq_latch   = 3'b100,
		op_irq_reload  = 3'b101,
		op_irq_disable = 3'b110,
		op_irq_enable  = 3'b111
	} reg_op_e;

	typedef enum logic [1:0] {
		a12_idle = 2'd0,
		a12_high = 2'd1,
		a12_low  = 2'd2
	} a12_state_e;

endpackage

`default_nettype wire

// File: map_testdata.txt
# op then hex args, A takes a decimal edge count; S expects {srm.ce, srm.we}
# W addr data | P cpu_addr prg_addr | S cpu_addr ce_we | C/M ppu_addr chr_addr/a10 | I irq
W 8000 00
W 8001 13
W 8000 01
W 8001 22
W 8000 02
W 8001 31
W 8000 03
W 8001 44
W 8000 04
W 8001 55
W 8000 05
W 8001 66
W 8000 06
W 8001 05
W 8000 07
W 8001 09
P 8123 0A123
P A456 12456
P C789 7C789
P E001 7E001
C 0123 04923
C 0C45 08C45
C 1400 11000
W 8000 C0
P 8123 7C123
P A456 12456
P C789 0A789
P E001 7E001
C 0123 0C523
C 1C45 08C45
C 0C10 19810
M 2400 1
W A000 01
M 2800 1
M 2400 0
S 6010 0
W A001 80
S 6010 3
W A001 C0
S 6010 2
W C000 02
W C001 00
W E001 00
A 7
I 0
A 9
I 0
A 8
I 1
W E000 00
I 0
A 24
I 0
W E001 00
A 16
I 0
A 8
I 1

// File: mmc3_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "map_consts.svh"

module mmc3_regs (
	input  logic                 clk,
	input  logic                 rst_n,
	input  map_pkg::cpu_bus_t    cpu,
	input  map_pkg::map_cfg_t    cfg,
	output map_pkg::reg_file_t   regs,
	output logic                 irq_wr,
	output map_pkg::reg_op_e     irq_op,
	output logic [7:0]           irq_data
);
	import map_pkg::*;

	logic    wr_stb;
	reg_op_e op;

	// ------------------------------------------------------------
	// write decode.
	// ------------------------------------------------------------

	// one clock per CPU write into 0x8000-0xFFFF.
	assign wr_stb = cpu.m3 && !cpu.rw && cpu.addr[15];
	assign op     = reg_op_e'({cpu.addr[14:13], cpu.addr[0]});

	// irq opcodes all live in the upper half, a14 set.
	assign irq_wr   = wr_stb && cpu.addr[14];
	assign irq_op   = op;
	assign irq_data = cpu.data;

	// ------------------------------------------------------------
	// register file.
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			regs.bank_sel <= 3'd0;
			regs.prg_mode <= 1'b0;
			regs.chr_inv  <= 1'b0;
			for (int i = 0; i < 8; i++) begin
				regs.r[i] <= `MAP_REG_DEFAULT;
			end
			// board strap picks the mirroring until software writes it.
			regs.mir_v  <= !cfg.mir_h;
			regs.ram_en <= 1'b0;
			regs.ram_wp <= 1'b0;
		end else if (wr_stb) begin
			case (op)
				op_bank_sel: begin
					regs.bank_sel <= cpu.data[2:0];
					regs.prg_mode <= cpu.data[6];
					regs.chr_inv  <= cpu.data[7];
				end
				op_bank_data: begin
					regs.r[regs.bank_sel] <= cpu.data;
				end
				op_mirror: begin
					// 0 selects vertical, 1 horizontal.
					regs.mir_v <= !cpu.data[0];
				end
				op_ram_prot: begin
					regs.ram_en <= cpu.data[7];
					regs.ram_wp <= cpu.data[6];
				end
				default: begin
					// irq opcodes are handled by irq_acc.
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: tb_map_004_s3.sv
`timescale 1ns/1ps
`default_nettype none

module tb_map_004_s3;
	import map_pkg::*;

	logic        clk = 1'b0;
	logic        rst_n;
	cpu_bus_t    cpu;
	ppu_bus_t    ppu;
	map_cfg_t    cfg;
	mem_ctrl_t   prg;
	mem_ctrl_t   chr;
	mem_ctrl_t   srm;
	logic        ciram_a10;
	logic        ciram_ce;
	logic        irq;
	logic [31:0] arg_a;
	logic [31:0] arg_b;
	logic [31:0] rng = 32'd82012;
	int          fd;
	int          ch;
	int          limit = 0;
	int          cycles = 0;
	int          checks = 0;
	int          errors = 0;

	always #20 clk = ~clk;

	map_004_s3 map_004_s3_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.cpu       (cpu),
		.ppu       (ppu),
		.cfg       (cfg),
		.prg       (prg),
		.chr       (chr),
		.srm       (srm),
		.ciram_a10 (ciram_a10),
		.ciram_ce  (ciram_ce),
		.irq       (irq)
	);

	// run limit armed once the data file length is known.
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("timeout, the run did not finish within %0d cycles", limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// helpers.
	// ------------------------------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end else begin
			$display("%s ok, %h", what, got);
		end
	endtask

	// one register write with m3 high for a single clock.
	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		cpu.addr <= addr;
		cpu.data <= data;
		cpu.rw   <= 1'b0;
		cpu.m2   <= 1'b1;
		cpu.m3   <= 1'b1;
		@(posedge clk);
		cpu.rw <= 1'b1;
		cpu.m2 <= 1'b0;
		cpu.m3 <= 1'b0;
	endtask

	// four clocks high and four low per edge.
	task automatic a12_pulses(input int count);
		repeat (count) begin
			@(posedge clk);
			ppu.addr[12] <= 1'b1;
			repeat (4) @(posedge clk);
			ppu.addr[12] <= 1'b0;
			repeat (3) @(posedge clk);
		end
	endtask

	// ------------------------------------------------------------
	// main sequence.
	// ------------------------------------------------------------
	initial begin
		rst_n    = 1'b0;
		cpu      = '0;
		cpu.rw   = 1'b1;
		ppu      = '0;
		ppu.oe_n = 1'b1;
		cfg      = '0;
		fd = $fopen("map_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open map_testdata.txt");
			$display("*** TEST FAILED ***");
			$finish;
		end else begin
			// 40 cycles per data line plus reset margin.
			ch = $fgetc(fd);
			while (ch != -1) begin
				if (ch == 10) limit = limit + 40;
				ch = $fgetc(fd);
			end
			limit = limit + 200;
			$fclose(fd);
			fd = $fopen("map_testdata.txt", "r");

			repeat (5) @(posedge clk);
			rst_n <= 1'b1;

			// random fill of all banks before the data file overwrites them.
			for (int i = 0; i < 8; i++) begin
				rng = xorshift(rng);
				cpu_write(16'h8000, 8'(i));
				cpu_write(16'h8001, rng[7:0]);
			end

			ch = $fgetc(fd);
			while (ch != -1) begin
				case (ch)
					"#": begin
						while (ch != 10 && ch != -1) begin
							ch = $fgetc(fd);
						end
					end
					"W": begin
						void'($fscanf(fd, "%h %h", arg_a, arg_b));
						cpu_write(arg_a[15:0], arg_b[7:0]);
					end
					"P", "S": begin
						void'($fscanf(fd, "%h %h", arg_a, arg_b));
						@(posedge clk);
						cpu.addr <= arg_a[15:0];
						cpu.rw   <= (ch == "P");
						cpu.m2   <= (ch == "S");
						@(negedge clk);
						if (ch == "P") begin
							check_value($sformatf("prg at %h", arg_a[15:0]),
								{13'd0, prg.addr}, arg_b);
						end else begin
							check_value($sformatf("srm ce,we at %h", arg_a[15:0]),
								{30'd0, srm.ce, srm.we}, arg_b);
						end
					end
					"C", "M": begin
						void'($fscanf(fd, "%h %h", arg_a, arg_b));
						@(posedge clk);
						ppu.addr <= arg_a[13:0];
						@(negedge clk);
						if (ch == "C") begin
							check_value($sformatf("chr at %h", arg_a[13:0]),
								{13'd0, chr.addr}, arg_b);
							// pattern fetches have A13 low, so the CIRAM line is high.
							check_value($sformatf("ciram_ce at %h", arg_a[13:0]),
								{31'd0, ciram_ce}, 32'd1);
						end else begin
							check_value($sformatf("ciram_a10 at %h", arg_a[13:0]),
								{31'd0, ciram_a10}, arg_b);
							// nametable fetches have A13 high.
							check_value($sformatf("ciram_ce at %h", arg_a[13:0]),
								{31'd0, ciram_ce}, 32'd0);
						end
					end
					"A": begin
						void'($fscanf(fd, "%d", arg_a));
						a12_pulses(arg_a);
					end
					"I": begin
						void'($fscanf(fd, "%h", arg_a));
						@(posedge clk);
						@(negedge clk);
						check_value("irq line", {31'd0, irq}, arg_a);
					end
					default: begin
						if (ch > 32) begin
							errors++;
							$display("unknown operation '%c' in map_testdata.txt", ch);
						end
					end
				endcase
				ch = $fgetc(fd);
			end
			$fclose(fd);

			$display("%0d checks, %0d errors", checks, errors);
			if (errors == 0) begin
				$display("*** TEST PASSED ***");
			end else begin
				$display("*** TEST FAILED ***");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire
